// ==== test/vfu_tests.txt ====
# P addr data | I name op vew vl vs1 vs2 vd use_rs1 rs1 id | E addr data be
# op: 0 add 1 sub 2 and 3 or 4 xor 5 minu 6 maxu, vew: 0 e8 1 e16 2 e32
P 04 80ff7f01fffe0010
P 05 00000001ffffffff
P 08 01017f0200030020
P 09 0000000200000001
I add_e8 0 0 8 2 1 3 0 0 0
E 0c 8100fe03ff010030 ff
I sub_e16_tail 1 1 6 2 1 4 0 0 1
E 10 7ffefffffffbfff0 ff
E 11 0000fffffffffffe 0f
I maxu_e32_tail 6 2 3 2 1 5 0 0 2
E 14 80ff7f01fffe0010 ff
E 15 00000002ffffffff 0f
I minu_e8_tail 5 0 5 2 1 6 0 0 3
E 18 01017f0100030010 1f
I xor_rs1_e16 4 1 4 9 1 7 1 1234abcd 0
E 1c 2b32d4cc5433abdd ff
I and_e32 2 2 4 2 1 8 0 0 1
E 20 00017f0000020000 ff
E 21 0000000000000001 ff
I or_rs1_e8 3 0 8 9 2 9 1 ffffff5a 2
E 24 5b5b7f5a5a5b5a7a ff

// ==== project.f ====
rtl/vfu_pkg.sv
rtl/vfu_simd_alu.sv
rtl/vfu_issue.sv
rtl/vfu_result_fifo.sv
rtl/vfu_writeback.sv
rtl/vfu_top.sv
test/tb_clock_gen.sv
test/vfu_checker.sv
test/tb_vfu.sv

// ==== Bender.yml ====
package:
  name: vfu

sources:
  - rtl/vfu_pkg.sv
  - rtl/vfu_simd_alu.sv
  - rtl/vfu_issue.sv
  - rtl/vfu_result_fifo.sv
  - rtl/vfu_writeback.sv
  - rtl/vfu_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/vfu_checker.sv
      - test/tb_vfu.sv

// ==== test/tb_vfu.sv ====
////////////////////////////////////////
// Vector unit testbench
// VRF model, file driven stimulus, checks
////////////////////////////////////////

`timescale 1ns/1ps

module tb_vfu;

  logic                                   clk_i;
  logic                                   rst_n_i;
  logic                                   req_valid_i;
  logic                                   req_ready_o;
  vfu_pkg::vfu_op_e                       req_op_i;
  vfu_pkg::vew_e                          req_vew_i;
  logic [7:0]                             req_vl_i;
  logic [7:0]                             req_vs1_i;
  logic [7:0]                             req_vs2_i;
  logic [7:0]                             req_vd_i;
  logic                                   req_use_rs1_i;
  logic [31:0]                            req_rs1_i;
  logic [1:0]                             req_id_i;
  logic [1:0]                             vrf_re_o;
  logic [1:0][7:0]                        vrf_raddr_o;
  logic [1:0][63:0]                       vrf_rdata_i;
  logic [1:0]                             vrf_rvalid_i;
  logic                                   vrf_we_o;
  logic [7:0]                             vrf_waddr_o;
  logic [63:0]                            vrf_wdata_o;
  logic [7:0]                             vrf_wbe_o;
  logic                                   vrf_wvalid_i;
  logic                                   rsp_valid_o;
  logic [1:0]                             rsp_id_o;

  // VRF contents and expected writes
  logic [63:0] mem [256];
  string       ins_name[$];
  int          ins_fields[$][10];
  logic [7:0]  exp_addr[$];
  logic [63:0] exp_data[$];
  logic [7:0]  exp_be[$];
  int          exp_ins[$];
  logic [1:0]  exp_id[$];

  logic [31:0] rng;
  int          errors;
  int          cycles;
  int          limit;
  int          wr_idx;
  int          rsp_cnt;
  bit          timed_out;
  bit          cur_use_rs1;
  bit          rd_armed [2];
  logic [7:0]  rd_addr [2];
  int          rd_cnt [2];
  int          wr_delay;
  logic [7:0]  pend_addr;
  logic [63:0] pend_data;
  logic [7:0]  pend_be;

  tb_clock_gen u_clk (
    .clk_o  (clk_i),
    .rst_n_o(rst_n_i)
  );

  vfu_top #(
    .NrWordsPerVreg(4)
  ) u_dut (
    .*
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Delay of 0 to 2 cycles
  task automatic next_delay(output int d);
    rng = xorshift(rng);
    d   = rng % 3;
  endtask

  task automatic load_tests();
    int    fd;
    int    r;
    int    f[10];
    string line;
    string kind;
    string name;
    logic [7:0]  a;
    logic [63:0] d;
    logic [7:0]  be;
    fd = $fopen("test/vfu_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test file");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      r = $fgets(line, fd);
      if (r == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      r = $sscanf(line, "%s", kind);
      if (kind == "P") begin
        r = $sscanf(line, "%s %h %h", kind, a, d);
        mem[a] = d;
      end else if (kind == "I") begin
        r = $sscanf(line, "%s %s %d %d %d %d %d %d %d %h %d", kind, name,
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
        ins_name.push_back(name);
        ins_fields.push_back(f);
      end else if (kind == "E") begin
        r = $sscanf(line, "%s %h %h %h", kind, a, d, be);
        exp_addr.push_back(a);
        exp_data.push_back(d);
        exp_be.push_back(be);
        exp_ins.push_back(ins_name.size() - 1);
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // VRF model
  ////////////////////////////////////////

  always @(negedge clk_i) begin : vrf_model
    if (rst_n_i) begin
      for (int i = 0; i < 2; i++) begin
        if (!vrf_re_o[i]) begin
          vrf_rvalid_i[i] = 1'b0;
          rd_armed[i]     = 1'b0;
        end else begin
          if (!rd_armed[i] || vrf_raddr_o[i] != rd_addr[i]) begin
            rd_armed[i] = 1'b1;
            rd_addr[i]  = vrf_raddr_o[i];
            next_delay(rd_cnt[i]);
          end
          if (rd_cnt[i] == 0) begin
            vrf_rvalid_i[i] = 1'b1;
            vrf_rdata_i[i]  = mem[vrf_raddr_o[i]];
          end else begin
            rd_cnt[i]--;
            vrf_rvalid_i[i] = 1'b0;
          end
        end
      end
      if (vrf_re_o[1] && cur_use_rs1) begin
        $display("vs1 was read although rs1 is the operand");
        errors++;
      end
      // A write offered on the last edge has been taken
      if (vrf_wvalid_i) begin
        for (int b = 0; b < 8; b++) begin
          if (pend_be[b]) begin
            mem[pend_addr][b*8 +: 8] = pend_data[b*8 +: 8];
          end
        end
        if (wr_idx >= exp_addr.size()) begin
          $display("Unexpected write to address %h", pend_addr);
          errors++;
        end else begin
          if (pend_addr != exp_addr[wr_idx]) begin
            $display("MISMATCH %s addr exp %h got %h", ins_name[exp_ins[wr_idx]],
                     exp_addr[wr_idx], pend_addr);
            errors++;
          end
          if (pend_data != exp_data[wr_idx]) begin
            $display("MISMATCH %s data exp %h got %h", ins_name[exp_ins[wr_idx]],
                     exp_data[wr_idx], pend_data);
            errors++;
          end
          if (pend_be != exp_be[wr_idx]) begin
            $display("MISMATCH %s be exp %h got %h", ins_name[exp_ins[wr_idx]],
                     exp_be[wr_idx], pend_be);
            errors++;
          end
        end
        wr_idx++;
        vrf_wvalid_i = 1'b0;
        next_delay(wr_delay);
      end else if (vrf_we_o) begin
        if (wr_delay == 0) begin
          vrf_wvalid_i = 1'b1;
          pend_addr    = vrf_waddr_o;
          pend_data    = vrf_wdata_o;
          pend_be      = vrf_wbe_o;
        end else begin
          wr_delay--;
        end
      end
    end
  end

  // Completion pulses in instruction order
  always @(negedge clk_i) begin : rsp_monitor
    if (rsp_valid_o) begin
      if (exp_id.size() == 0) begin
        $display("Completion pulse without an instruction");
        errors++;
      end else begin
        if (rsp_id_o != exp_id[0]) begin
          $display("MISMATCH %s rsp_id exp %0d got %0d", ins_name[rsp_cnt],
                   exp_id[0], rsp_id_o);
          errors++;
        end
        void'(exp_id.pop_front());
      end
      rsp_cnt++;
    end
  end

  always @(posedge clk_i) begin : cycle_count
    cycles++;
    if (cycles >= limit) begin
      timed_out = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Stimulus and verdict
  ////////////////////////////////////////

  initial begin : main
    int k;
    rng           = 32'h9ab29fc1;
    errors        = 0;
    cycles        = 0;
    limit         = 1000;
    wr_idx        = 0;
    rsp_cnt       = 0;
    wr_delay      = 0;
    timed_out     = 1'b0;
    cur_use_rs1   = 1'b0;
    req_valid_i   = 1'b0;
    req_op_i      = vfu_pkg::VADD;
    req_vew_i     = vfu_pkg::EW_8;
    req_vl_i      = '0;
    req_vs1_i     = '0;
    req_vs2_i     = '0;
    req_vd_i      = '0;
    req_use_rs1_i = 1'b0;
    req_rs1_i     = '0;
    req_id_i      = '0;
    vrf_rdata_i   = '0;
    vrf_rvalid_i  = '0;
    vrf_wvalid_i  = 1'b0;
    // Fill pattern that depends on every address bit
    for (int a = 0; a < 256; a++) begin
      mem[a] = {8{a[7:0]}} ^ 64'h5a5a_0000_a5a5_0000;
    end
    load_tests();
    limit = 40 * exp_addr.size();
    @(posedge rst_n_i);
    k = 0;
    while (k < ins_name.size() && !timed_out) begin
      @(negedge clk_i);
      if (req_valid_i) begin
        req_valid_i = 1'b0;
      end else if (req_ready_o) begin
        req_valid_i   = 1'b1;
        req_op_i      = vfu_pkg::vfu_op_e'(ins_fields[k][0]);
        req_vew_i     = vfu_pkg::vew_e'(ins_fields[k][1]);
        req_vl_i      = ins_fields[k][2];
        req_vs1_i     = ins_fields[k][3];
        req_vs2_i     = ins_fields[k][4];
        req_vd_i      = ins_fields[k][5];
        req_use_rs1_i = ins_fields[k][6];
        req_rs1_i     = ins_fields[k][7];
        req_id_i      = ins_fields[k][8];
        cur_use_rs1   = ins_fields[k][6];
        exp_id.push_back(req_id_i);
        k++;
      end
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (rsp_cnt < ins_name.size() && !timed_out) begin
      @(negedge clk_i);
    end
    // Last write is taken on the falling edge that sees its response
    @(posedge clk_i);
    if (rsp_cnt < ins_name.size()) begin
      $display("Timeout after %0d cycles with %0d of %0d responses", cycles, rsp_cnt,
               ins_name.size());
      errors++;
    end else if (wr_idx != exp_addr.size()) begin
      $display("Wrote %0d words but expected %0d", wr_idx, exp_addr.size());
      errors++;
    end
    errors = errors + u_dut.u_checker.assert_errs;
    $display("errors: %0d, writes: %0d, responses: %0d", errors, wr_idx, rsp_cnt);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== test/vfu_checker.sv ====
////////////////////////////////////////
// Port assertions for the vector unit
////////////////////////////////////////

`timescale 1ns/1ps

module vfu_checker (
  input logic                                  clk_i,
  input logic                                  rst_n_i,
  input logic                                  req_ready_o,
  input logic                                  vrf_we_o,
  input logic [vfu_pkg::VregAddrWidth-1:0]     vrf_waddr_o,
  input logic [vfu_pkg::WordWidth-1:0]         vrf_wdata_o,
  input logic [vfu_pkg::WordBytes-1:0]         vrf_wbe_o,
  input logic                                  vrf_wvalid_i,
  input logic                                  rsp_valid_o
);

  // Number of failed assertions
  int assert_errs = 0;

  // Write port held until the VRF takes it
  write_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vrf_we_o && !vrf_wvalid_i |=> vrf_we_o && $stable(vrf_waddr_o) &&
    $stable(vrf_wdata_o) && $stable(vrf_wbe_o))
    else begin
      $error("write port changed before wvalid");
      assert_errs++;
    end

  rsp_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |=> !rsp_valid_o)
    else begin
      $error("rsp_valid_o high for two cycles");
      assert_errs++;
    end

  // No new request while writes of the last one are outstanding
  ready_pending_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vrf_we_o |-> !req_ready_o)
    else begin
      $error("req_ready_o high while writes pending");
      assert_errs++;
    end

endmodule

bind vfu_top vfu_checker u_checker (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .req_ready_o (req_ready_o),
  .vrf_we_o    (vrf_we_o),
  .vrf_waddr_o (vrf_waddr_o),
  .vrf_wdata_o (vrf_wdata_o),
  .vrf_wbe_o   (vrf_wbe_o),
  .vrf_wvalid_i(vrf_wvalid_i),
  .rsp_valid_o (rsp_valid_o)
);

// ==== test/tb_clock_gen.sv ====
////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held for three cycles, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== rtl/vfu_top.sv ====
////////////////////////////////////////
// Vector functional unit top level
// Issue with ALU, result buffer and
// VRF writeback
////////////////////////////////////////

`timescale 1ns/1ps

module vfu_top #(
  parameter int unsigned NrWordsPerVreg = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  // Request
  input  logic                                   req_valid_i,
  output logic                                   req_ready_o,
  input  vfu_pkg::vfu_op_e                       req_op_i,
  input  vfu_pkg::vew_e                          req_vew_i,
  input  logic [vfu_pkg::VlWidth-1:0]            req_vl_i,
  input  logic [vfu_pkg::VregAddrWidth-1:0]      req_vs1_i,
  input  logic [vfu_pkg::VregAddrWidth-1:0]      req_vs2_i,
  input  logic [vfu_pkg::VregAddrWidth-1:0]      req_vd_i,
  input  logic                                   req_use_rs1_i,
  input  logic [vfu_pkg::ELEN-1:0]               req_rs1_i,
  input  logic [vfu_pkg::IdWidth-1:0]            req_id_i,
  // VRF read, bit 0 is vs2 and bit 1 is vs1
  output logic [1:0]                             vrf_re_o,
  output logic [1:0][vfu_pkg::VregAddrWidth-1:0] vrf_raddr_o,
  input  logic [1:0][vfu_pkg::WordWidth-1:0]     vrf_rdata_i,
  input  logic [1:0]                             vrf_rvalid_i,
  // VRF write
  output logic                                   vrf_we_o,
  output logic [vfu_pkg::VregAddrWidth-1:0]      vrf_waddr_o,
  output logic [vfu_pkg::WordWidth-1:0]          vrf_wdata_o,
  output logic [vfu_pkg::WordBytes-1:0]          vrf_wbe_o,
  input  logic                                   vrf_wvalid_i,
  // Completion
  output logic                                   rsp_valid_o,
  output logic [vfu_pkg::IdWidth-1:0]            rsp_id_o
);

  vfu_pkg::vfu_entry_t alu_entry;
  vfu_pkg::vfu_entry_t head_entry;
  logic                alu_push;
  logic                fifo_empty;
  logic                fifo_full;
  logic                fifo_pop;
  logic                last_done;

  vfu_issue #(
    .NrWordsPerVreg(NrWordsPerVreg)
  ) u_issue (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_op_i     (req_op_i),
    .req_vew_i    (req_vew_i),
    .req_vl_i     (req_vl_i),
    .req_vs1_i    (req_vs1_i),
    .req_vs2_i    (req_vs2_i),
    .req_vd_i     (req_vd_i),
    .req_use_rs1_i(req_use_rs1_i),
    .req_rs1_i    (req_rs1_i),
    .req_id_i     (req_id_i),
    .vrf_re_o     (vrf_re_o),
    .vrf_raddr_o  (vrf_raddr_o),
    .vrf_rdata_i  (vrf_rdata_i),
    .vrf_rvalid_i (vrf_rvalid_i),
    .fifo_full_i  (fifo_full),
    .last_done_i  (last_done),
    .entry_o      (alu_entry),
    .entry_valid_o(alu_push),
    .rsp_id_o     (rsp_id_o)
  );

  vfu_result_fifo u_result_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .push_i (alu_push),
    .entry_i(alu_entry),
    .pop_i  (fifo_pop),
    .entry_o(head_entry),
    .empty_o(fifo_empty),
    .full_o (fifo_full)
  );

  vfu_writeback u_writeback (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .entry_i     (head_entry),
    .empty_i     (fifo_empty),
    .vrf_wvalid_i(vrf_wvalid_i),
    .pop_o       (fifo_pop),
    .vrf_we_o    (vrf_we_o),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .last_done_o (last_done),
    .rsp_valid_o (rsp_valid_o)
  );

endmodule

// ==== rtl/vfu_writeback.sv ====
////////////////////////////////////////
// VRF writeback and completion pulse
////////////////////////////////////////

`timescale 1ns/1ps

module vfu_writeback (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  vfu_pkg::vfu_entry_t               entry_i,
  input  logic                              empty_i,
  input  logic                              vrf_wvalid_i,
  output logic                              pop_o,
  output logic                              vrf_we_o,
  output logic [vfu_pkg::VregAddrWidth-1:0] vrf_waddr_o,
  output logic [vfu_pkg::WordWidth-1:0]     vrf_wdata_o,
  output logic [vfu_pkg::WordBytes-1:0]     vrf_wbe_o,
  output logic                              last_done_o,
  output logic                              rsp_valid_o
);

  logic rsp_valid_q;

  // Head entry stays on the port until the VRF takes it
  assign vrf_we_o    = !empty_i;
  assign vrf_waddr_o = entry_i.waddr;
  assign vrf_wdata_o = entry_i.data;
  assign vrf_wbe_o   = entry_i.be;

  assign pop_o = vrf_we_o && vrf_wvalid_i;

  // Last word of the instruction written
  assign last_done_o = pop_o && entry_i.last;

  ////////////////////////////////////////
  // Completion
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin : rsp_ff
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= last_done_o;
    end
  end

  assign rsp_valid_o = rsp_valid_q;

endmodule

// ==== rtl/vfu_result_fifo.sv ====
////////////////////////////////////////
// Two-entry result buffer
// Head falls through on push when empty
////////////////////////////////////////

`timescale 1ns/1ps

module vfu_result_fifo (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                push_i,
  input  vfu_pkg::vfu_entry_t entry_i,
  input  logic                pop_i,
  output vfu_pkg::vfu_entry_t entry_o,
  output logic                empty_o,
  output logic                full_o
);

  vfu_pkg::vfu_entry_t mem_q [2];
  logic                rptr_q;
  logic                wptr_q;
  logic [1:0]          cnt_q;
  logic                do_write;
  logic                do_read;

  // Bypass when empty, nothing is stored if popped at once
  assign entry_o  = (cnt_q == 2'd0) ? entry_i : mem_q[rptr_q];
  assign empty_o  = (cnt_q == 2'd0) && !push_i;
  assign full_o   = cnt_q == 2'd2;
  assign do_write = push_i && !(pop_i && cnt_q == 2'd0);
  assign do_read  = pop_i && cnt_q != 2'd0;

  always_ff @(posedge clk_i) begin : mem_ff
    if (do_write) begin
      mem_q[wptr_q] <= entry_i;
    end
  end

  always_ff @(posedge clk_i) begin : ptr_ff
    if (!rst_n_i) begin
      rptr_q <= 1'b0;
      wptr_q <= 1'b0;
      cnt_q  <= 2'd0;
    end else begin
      if (do_write) begin
        wptr_q <= !wptr_q;
      end
      if (do_read) begin
        rptr_q <= !rptr_q;
      end
      unique case ({do_write, do_read})
        2'b10:   cnt_q <= cnt_q + 2'd1;
        2'b01:   cnt_q <= cnt_q - 2'd1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

// ==== rtl/vfu_issue.sv ====
////////////////////////////////////////
// Issue stage of the vector unit
// Holds the request, reads VRF words and
// launches one ALU operation per word
////////////////////////////////////////

`timescale 1ns/1ps

module vfu_issue #(
  parameter int unsigned NrWordsPerVreg = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   req_valid_i,
  output logic                                   req_ready_o,
  input  vfu_pkg::vfu_op_e                       req_op_i,
  input  vfu_pkg::vew_e                          req_vew_i,
  input  logic [vfu_pkg::VlWidth-1:0]            req_vl_i,
  input  logic [vfu_pkg::VregAddrWidth-1:0]      req_vs1_i,
  input  logic [vfu_pkg::VregAddrWidth-1:0]      req_vs2_i,
  input  logic [vfu_pkg::VregAddrWidth-1:0]      req_vd_i,
  input  logic                                   req_use_rs1_i,
  input  logic [vfu_pkg::ELEN-1:0]               req_rs1_i,
  input  logic [vfu_pkg::IdWidth-1:0]            req_id_i,
  output logic [1:0]                             vrf_re_o,
  output logic [1:0][vfu_pkg::VregAddrWidth-1:0] vrf_raddr_o,
  input  logic [1:0][vfu_pkg::WordWidth-1:0]     vrf_rdata_i,
  input  logic [1:0]                             vrf_rvalid_i,
  input  logic                                   fifo_full_i,
  input  logic                                   last_done_i,
  output vfu_pkg::vfu_entry_t                    entry_o,
  output logic                                   entry_valid_o,
  output logic [vfu_pkg::IdWidth-1:0]            rsp_id_o
);

  typedef logic [vfu_pkg::VregAddrWidth-1:0] addr_t;
  typedef logic [vfu_pkg::VlWidth:0]         cnt_ext_t;

  // Control state
  logic started_q;
  logic active_q;
  logic pending_q;
  logic accept;
  logic launch;
  logic last_word;

  // Latched request
  vfu_pkg::vfu_op_e              op_q;
  vfu_pkg::vew_e                 vew_q;
  logic [vfu_pkg::VlWidth-1:0]   vl_q;
  logic                          use_rs1_q;
  logic [vfu_pkg::ELEN-1:0]      rs1_q;
  logic [vfu_pkg::IdWidth-1:0]   id_q;
  addr_t                         vs1_addr_q;
  addr_t                         vs2_addr_q;
  addr_t                         vd_addr_q;

  // Element progress
  logic [vfu_pkg::VlWidth-1:0]   elem_cnt_q;
  cnt_ext_t                      per_word;
  cnt_ext_t                      elem_next;
  logic [vfu_pkg::WordBytes-1:0] word_be;

  // Operands and ALU side
  vfu_pkg::vfu_word_u            scalar_word;
  vfu_pkg::vfu_word_u            opa;
  vfu_pkg::vfu_word_u            opb;
  vfu_pkg::vfu_word_u            alu_result;
  logic                          alu_valid;
  addr_t                         pipe_waddr_q;
  logic [vfu_pkg::WordBytes-1:0] pipe_be_q;
  logic                          pipe_last_q;

  // One instruction at a time, until its completion is seen
  assign req_ready_o = started_q && !active_q && !pending_q;
  assign accept      = req_valid_i && req_ready_o;

  assign vrf_re_o    = {active_q && !use_rs1_q, active_q};
  assign vrf_raddr_o = {vs1_addr_q, vs2_addr_q};
  assign launch      = active_q && vrf_rvalid_i[0] && (use_rs1_q || vrf_rvalid_i[1]) &&
                       !fifo_full_i;

  // 8, 4 or 2 elements per word
  assign per_word  = cnt_ext_t'(vfu_pkg::WordBytes >> vew_q);
  assign elem_next = cnt_ext_t'(elem_cnt_q) + per_word;
  assign last_word = elem_next >= cnt_ext_t'(vl_q);

  // Byte enable of elements below vl
  always_comb begin : be_proc
    cnt_ext_t idx;
    for (int i = 0; i < vfu_pkg::WordBytes; i++) begin
      idx        = cnt_ext_t'(elem_cnt_q) + cnt_ext_t'(i >> vew_q);
      word_be[i] = idx < cnt_ext_t'(vl_q);
    end
  end

  ////////////////////////////////////////
  // Operands
  ////////////////////////////////////////

  always_comb begin : scalar_proc
    scalar_word = '0;
    unique case (vew_q)
      vfu_pkg::EW_8: begin
        for (int i = 0; i < vfu_pkg::WordBytes; i++) begin
          scalar_word.b[i] = rs1_q[7:0];
        end
      end
      vfu_pkg::EW_16: begin
        for (int i = 0; i < vfu_pkg::WordBytes / 2; i++) begin
          scalar_word.h[i] = rs1_q[15:0];
        end
      end
      default: begin
        for (int i = 0; i < vfu_pkg::NrLanes; i++) begin
          scalar_word.w[i] = rs1_q;
        end
      end
    endcase
  end

  // vs2 is the first operand
  assign opa = vrf_rdata_i[0];
  assign opb = use_rs1_q ? scalar_word : vfu_pkg::vfu_word_u'(vrf_rdata_i[1]);

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin : ctrl_ff
    if (!rst_n_i) begin
      started_q  <= 1'b0;
      active_q   <= 1'b0;
      pending_q  <= 1'b0;
      elem_cnt_q <= '0;
    end else begin
      started_q <= 1'b1;
      if (accept) begin
        active_q   <= 1'b1;
        pending_q  <= 1'b1;
        elem_cnt_q <= '0;
      end else begin
        if (launch) begin
          elem_cnt_q <= elem_next[vfu_pkg::VlWidth-1:0];
          if (last_word) begin
            active_q <= 1'b0;
          end
        end
        if (last_done_i) begin
          pending_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : req_ff
    if (accept) begin
      op_q       <= req_op_i;
      vew_q      <= req_vew_i;
      vl_q       <= req_vl_i;
      use_rs1_q  <= req_use_rs1_i;
      rs1_q      <= req_rs1_i;
      id_q       <= req_id_i;
      // Base word of each register
      vs1_addr_q <= addr_t'(req_vs1_i) * addr_t'(NrWordsPerVreg);
      vs2_addr_q <= addr_t'(req_vs2_i) * addr_t'(NrWordsPerVreg);
      vd_addr_q  <= addr_t'(req_vd_i) * addr_t'(NrWordsPerVreg);
    end else if (launch) begin
      vs1_addr_q <= vs1_addr_q + addr_t'(1);
      vs2_addr_q <= vs2_addr_q + addr_t'(1);
      vd_addr_q  <= vd_addr_q + addr_t'(1);
    end
  end

  // Write info travels beside the ALU register
  always_ff @(posedge clk_i) begin : pipe_ff
    if (launch) begin
      pipe_waddr_q <= vd_addr_q;
      pipe_be_q    <= word_be;
      pipe_last_q  <= last_word;
    end
  end

  vfu_simd_alu u_alu (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .op_i    (op_q),
    .vew_i   (vew_q),
    .a_i     (opa),
    .b_i     (opb),
    .valid_i (launch),
    .hold_i  (fifo_full_i),
    .result_o(alu_result),
    .valid_o (alu_valid)
  );

  assign entry_o = '{
    data:  alu_result,
    waddr: pipe_waddr_q,
    be:    pipe_be_q,
    last:  pipe_last_q,
    spare: 1'b0
  };

  // Push only when the buffer has room
  assign entry_valid_o = alu_valid && !fifo_full_i;
  assign rsp_id_o      = id_q;

endmodule

// ==== rtl/vfu_simd_alu.sv ====
////////////////////////////////////////
// Packed SIMD integer ALU, one stage
// 8, 16 or 32-bit elements per word
////////////////////////////////////////

`timescale 1ns/1ps

module vfu_simd_alu (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  vfu_pkg::vfu_op_e   op_i,
  input  vfu_pkg::vew_e      vew_i,
  input  vfu_pkg::vfu_word_u a_i,
  input  vfu_pkg::vfu_word_u b_i,
  input  logic               valid_i,
  input  logic               hold_i,
  output vfu_pkg::vfu_word_u result_o,
  output logic               valid_o
);

  typedef logic [vfu_pkg::ELEN-1:0] elem_t;

  vfu_pkg::vfu_word_u result_d;
  vfu_pkg::vfu_word_u result_q;
  logic               valid_q;

  // Narrow elements come in zero-extended, the low bits are kept
  function automatic elem_t elem_op(input vfu_pkg::vfu_op_e op, input elem_t a, input elem_t b);
    elem_t res;
    unique case (op)
      vfu_pkg::VADD:  res = a + b;
      vfu_pkg::VSUB:  res = a - b;
      vfu_pkg::VAND:  res = a & b;
      vfu_pkg::VOR:   res = a | b;
      vfu_pkg::VXOR:  res = a ^ b;
      vfu_pkg::VMINU: res = (a < b) ? a : b;
      vfu_pkg::VMAXU: res = (a > b) ? a : b;
      default:        res = '0;
    endcase
    return res;
  endfunction

  always_comb begin : simd_proc
    elem_t tmp;
    result_d = '0;
    unique case (vew_i)
      vfu_pkg::EW_8: begin
        for (int i = 0; i < vfu_pkg::WordBytes; i++) begin
          tmp           = elem_op(op_i, elem_t'(a_i.b[i]), elem_t'(b_i.b[i]));
          result_d.b[i] = tmp[7:0];
        end
      end
      vfu_pkg::EW_16: begin
        for (int i = 0; i < vfu_pkg::WordBytes / 2; i++) begin
          tmp           = elem_op(op_i, elem_t'(a_i.h[i]), elem_t'(b_i.h[i]));
          result_d.h[i] = tmp[15:0];
        end
      end
      default: begin
        for (int i = 0; i < vfu_pkg::NrLanes; i++) begin
          result_d.w[i] = elem_op(op_i, a_i.w[i], b_i.w[i]);
        end
      end
    endcase
  end

  ////////////////////////////////////////
  // Output register, held on stall
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin : valid_ff
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (!hold_i) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin : result_ff
    if (!hold_i && valid_i) begin
      result_q <= result_d;
    end
  end

  assign result_o = result_q;
  assign valid_o  = valid_q;

endmodule

// ==== rtl/vfu_pkg.sv ====
////////////////////////////////////////
// Vector functional unit definitions
// Widths, operation and element width
// encodings, data word and buffer entry
////////////////////////////////////////

package vfu_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Widest element and number of 32-bit lanes
  localparam int unsigned ELEN    = 32;
  localparam int unsigned NrLanes = 2;

  // One VRF word
  localparam int unsigned WordWidth = 64;
  localparam int unsigned WordBytes = 8;

  localparam int unsigned VregAddrWidth = 8;
  localparam int unsigned IdWidth       = 2;
  localparam int unsigned VlWidth       = 8;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Value doubles as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VOR   = 3'd3,
    VXOR  = 3'd4,
    VMINU = 3'd5,
    VMAXU = 3'd6
  } vfu_op_e;

  // One VRF word, seen as raw bits or as elements
  typedef union packed {
    logic [WordWidth-1:0]                raw;
    logic [WordBytes-1:0][7:0]           b;
    logic [WordBytes/2-1:0][15:0]        h;
    logic [NrLanes-1:0][ELEN-1:0]        w;
  } vfu_word_u;

  // Result waiting for writeback
  typedef struct packed {
    vfu_word_u                data;
    logic [VregAddrWidth-1:0] waddr;
    logic [WordBytes-1:0]     be;
    logic                     last;
    logic                     spare;
  } vfu_entry_t;

endpackage
